/* bench/guess_game_checker.sv */
`timescale 1ns/1ns

module guess_game_checker import game_data_pkg::*, game_ctrl_pkg::*; #(
  parameter int SHOW_CYCLES   = 8,
  parameter int INPUT_LIMIT   = 64,
  parameter int RESULT_CYCLES = 4,
  parameter int MAX_TRIES     = 3
) (
  input  logic            CLK,
  input  game_state_t     state,
  input  result_t         result,
  input  score_t          score,
  input  logic [5:0][6:0] seg,
  input  logic            led,
  input  logic            decide,
  input  logic [47:0]     rec,
  input  int              test_num,
  output int              checked,
  output int              errors
);

  // Active-low gfedcba for 0 to 9
  localparam logic [6:0] SEG_TAB [10] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19,
                                         7'h12, 7'h02, 7'h78, 7'h00, 7'h10};
  localparam logic [6:0] BLANK = 7'h7F;

  int test_err;
  int prev_tries;  // Score before the current test
  int prev_rounds;

  // Position value after n select strobes from zero
  function automatic int digit_after(int n);
    if (n == 0)
      return 0;
    return ((n - 1) % 9) + 1;
  endfunction

  task automatic compare(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("** Error at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
      errors++;
      test_err++;
    end
  endtask

  task automatic report(input string msg);
    $display("%0t ns: %s", $time, msg);
    errors++;
    test_err++;
  endtask

  task automatic check_idle(input int tries, input int rounds);
    compare("led", 0, led);
    compare("score.tries_left", tries, score.tries_left);
    compare("score.rounds_won", rounds, score.rounds_won);
    for (int i = 0; i < 4; i++)
      compare($sformatf("seg[%0d]", i), BLANK, seg[i]);
    compare("seg[4]", SEG_TAB[tries], seg[4]);
    compare("seg[5]", SEG_TAB[rounds], seg[5]);
  endtask

  task automatic check_round(input logic [47:0] r);
    int len;
    int dec_at;
    int valid_at;
    int dig [3];
    game_state_t outcome;
    outcome  = game_state_t'(r[15:12]);
    dig[0]   = digit_after(r[35:32] + r[23:20]); // All-select strobes land on d0
    dig[1]   = digit_after(r[31:28]);
    dig[2]   = digit_after(r[27:24]);
    len      = 1; // First INPUT cycle seen by the previous test
    dec_at   = -1;
    valid_at = -1;
    @(posedge CLK);
    if (state == READY) begin
      check_idle(prev_tries, prev_rounds);
      @(posedge CLK);
      if (state != QUE)
        report("accepted start did not lead to QUE");
      len = 0;
      while (state == QUE) begin
        len++;
        compare("led", 1, led);
        for (int i = 0; i < 3; i++)
          if (len > 1) // Display trails state by one cycle
            compare($sformatf("seg[%0d]", i), SEG_TAB[r[36+4*i +: 4]], seg[i]);
        @(posedge CLK);
      end
      compare("QUE length", SHOW_CYCLES, len);
      len = 0;
    end
    while (state == INPUT) begin
      len++;
      if (decide)
        dec_at = len;
      if (result.valid) begin
        valid_at = len;
        compare("result.hits", r[11:8], result.hits);
        compare("result.exact", r[11:8] == 3, result.exact);
      end
      @(posedge CLK);
    end
    if (r[19:16] == 4'h1)
      compare("INPUT length", INPUT_LIMIT, len);
    else if (dec_at < 0)
      report("decide was never seen in INPUT");
    else if (valid_at != dec_at + 2)
      report("result.valid did not come two cycles after decide");
    compare("state", outcome, state);
    compare("score.tries_left", r[7:4], score.tries_left);
    compare("score.rounds_won", r[3:0], score.rounds_won);
    for (int i = 0; i < 3; i++)
      compare($sformatf("seg[%0d]", i), SEG_TAB[dig[i]], seg[i]);
    if (outcome inside {WRONG, GOOD, OUCH}) begin
      len = 0;
      while (state == outcome) begin
        len++;
        if (len > 1) begin // Display trails state by one cycle
          compare("seg[4]", SEG_TAB[r[7:4]], seg[4]);
          compare("seg[5]", SEG_TAB[r[3:0]], seg[5]);
          if (outcome == WRONG)
            compare("seg[3]", SEG_TAB[r[11:8]], seg[3]);
        end
        @(posedge CLK);
      end
      compare("result state length", RESULT_CYCLES, len);
      compare("state", (outcome == GOOD) ? READY : INPUT, state);
    end
  endtask

  initial begin
    checked     = 0;
    errors      = 0;
    prev_tries  = MAX_TRIES;
    prev_rounds = 0;
    forever begin
      wait (test_num > checked);
      test_err = 0;
      case (rec[19:16])
        4'h2: begin // Start with a zero digit
          repeat (2) @(posedge CLK);
          compare("state", READY, state);
          check_idle(rec[7:4], rec[3:0]);
        end
        4'h4: begin
          @(posedge CLK);
          while (state != READY)
            @(posedge CLK);
          compare("score.tries_left", rec[7:4], score.tries_left);
          compare("score.rounds_won", rec[3:0], score.rounds_won);
        end
        default: check_round(rec);
      endcase
      prev_tries  = rec[7:4];
      prev_rounds = rec[3:0];
      $display("Test %0d kind %0h: %s", test_num, rec[19:16],
               (test_err == 0) ? "passed" : "has errors");
      checked = checked + 1;
    end
  end

endmodule

/* bench/guess_game_input.txt */
// qqq n0 n1 n2 nall kind exp_state hits tries rounds, one hex digit each except qqq (d2 d1 d0)
// kind 0 decide, 1 timeout, 2 start with zero digit, 4 clear
105000022030
123325007220
123321008321
98758A207211
98710001B001
000000042030
456654008331
222000019021
222B2200A322
000000042030

/* bench/guess_game_tb.sv */
`timescale 1ns/1ns

module guess_game_tb import game_data_pkg::*, game_ctrl_pkg::*; ();

  localparam int SHOW_CYCLES   = 8;
  localparam int INPUT_LIMIT   = 64;
  localparam int RESULT_CYCLES = 4;
  localparam int MAX_TRIES     = 3;
  localparam int WIN_ROUNDS    = 2;
  localparam int CLK_PERIOD    = 40;
  localparam int MAX_RECS      = 32;

  logic            CLK;
  logic            RST;
  question_t       question;
  logic            question_valid;
  logic            start;
  step_t           step;
  logic            decide;
  logic            clear;
  game_state_t     state;
  result_t         result;
  score_t          score;
  logic [5:0][6:0] seg;
  logic            led;

  logic [47:0] recs [MAX_RECS];
  logic [47:0] rec;
  int          n_recs;
  int          test_num;
  int          checked;
  int          errors;
  logic        loaded;
  longint      limit;

  guess_game_top #(
    .SHOW_CYCLES (SHOW_CYCLES), .INPUT_LIMIT (INPUT_LIMIT), .RESULT_CYCLES (RESULT_CYCLES),
    .MAX_TRIES (MAX_TRIES), .WIN_ROUNDS (WIN_ROUNDS)
  ) UUT (
    .CLK (CLK), .RST (RST), .question (question), .question_valid (question_valid),
    .start (start), .step (step), .decide (decide), .clear (clear), .state (state),
    .result (result), .score (score), .seg (seg), .led (led)
  );

  guess_game_checker #(
    .SHOW_CYCLES (SHOW_CYCLES), .INPUT_LIMIT (INPUT_LIMIT), .RESULT_CYCLES (RESULT_CYCLES),
    .MAX_TRIES (MAX_TRIES)
  ) u_checker (
    .CLK (CLK), .state (state), .result (result), .score (score), .seg (seg), .led (led),
    .decide (decide), .rec (rec), .test_num (test_num), .checked (checked), .errors (errors)
  );

  initial CLK = 1'b0;
  always #(CLK_PERIOD / 2) CLK = ~CLK;

  // Runs from one falling edge to the next
  task automatic pulse_step(input logic [2:0] sel);
    step = step_t'(sel);
    @(negedge CLK);
    step = '0;
  endtask

  task automatic pulse_start(input question_t q);
    question       = q;
    question_valid = 1'b1;
    start          = 1'b1;
    @(negedge CLK);
    start          = 1'b0;
    question_valid = 1'b0;
  endtask

  task automatic play_record(input logic [47:0] r);
    case (r[19:16])
      4'h2: pulse_start(r[47:36]);
      4'h4: begin
        clear = 1'b1;
        @(negedge CLK);
        clear = 1'b0;
      end
      default: begin
        if (state == READY) begin
          pulse_start(r[47:36]);
          while (state != INPUT)
            @(negedge CLK);
        end
        repeat (r[35:32]) pulse_step(3'b001);
        repeat (r[31:28]) pulse_step(3'b010);
        repeat (r[27:24]) pulse_step(3'b100);
        repeat (r[23:20]) pulse_step(3'b111); // sel0 must win
        if (r[19:16] == 4'h0) begin
          decide = 1'b1;
          @(negedge CLK);
          decide = 1'b0;
        end
      end
    endcase
  endtask

  initial begin
    RST            = 1'b1;
    question       = '0;
    question_valid = 1'b0;
    start          = 1'b0;
    step           = '0;
    decide         = 1'b0;
    clear          = 1'b0;
    rec            = '0;
    test_num       = 0;
    n_recs         = 0;
    loaded         = 1'b0;
    for (int i = 0; i < MAX_RECS; i++)
      recs[i] = '0;
    $readmemh("bench/guess_game_input.txt", recs);
    while (n_recs < MAX_RECS && recs[n_recs] !== '0 && !$isunknown(recs[n_recs]))
      n_recs++;
    loaded = 1'b1;
    repeat (10) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    for (int i = 0; i < n_recs; i++) begin
      @(negedge CLK);
      rec      = recs[i];
      test_num = i + 1;
      play_record(recs[i]);
      wait (checked == test_num);
    end
    @(negedge CLK);
    $display("Tests run: %0d, errors: %0d", n_recs, errors);
    if (errors == 0 && n_recs > 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  // Worst case per record covers all strobes, QUE, a full INPUT window and two result phases
  initial begin
    wait (loaded);
    limit = 20;
    for (int i = 0; i < n_recs; i++)
      limit += recs[i][35:32] + recs[i][31:28] + recs[i][27:24] + recs[i][23:20] +
               SHOW_CYCLES + INPUT_LIMIT + 2 * RESULT_CYCLES + 10;
    limit = limit * CLK_PERIOD;
    #(limit);
    $display("Watchdog expired after %0d ns, the tests did not finish", limit);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* common/game_ctrl_pkg.sv */
package game_ctrl_pkg;

  import game_data_pkg::*;

  // Code 4'b0110 is not used
  typedef enum logic [3:0] {
    READY = 4'b0010,
    QUE   = 4'b0011,
    INPUT = 4'b0100,
    WRONG = 4'b0111,
    GOOD  = 4'b1000,
    OUCH  = 4'b1001,
    WIN   = 4'b1010,
    LOSE  = 4'b1011
  } game_state_t;

  // Checker verdict for one guess
  typedef struct packed {
    logic  valid; // One-cycle strobe
    logic  exact; // All three positions match
    hits_t hits;
  } result_t;

  typedef struct packed {
    digit_t tries_left;
    digit_t rounds_won;
  } score_t;

endpackage

/* common/game_data_pkg.sv */
package game_data_pkg;

  // One decimal digit, 0 means "not set yet"
  typedef logic [3:0] digit_t;

  // Three digits, d0 sits in the low nibble
  typedef struct packed {
    digit_t d2;
    digit_t d1;
    digit_t d0;
  } question_t;

  // Committed guess, same layout so fields line up with the question
  typedef struct packed {
    digit_t d2;
    digit_t d1;
    digit_t d0;
  } guess_t;

  // Select strobes, one per entry digit
  typedef struct packed {
    logic sel2;
    logic sel1;
    logic sel0; // Highest priority
  } step_t;

  typedef logic [1:0] hits_t; // Matching positions, 0 to 3

endpackage

/* game_ctrl/game_fsm.sv */
`timescale 1ns/1ns

module game_fsm import game_data_pkg::*, game_ctrl_pkg::*; #(
  parameter int SHOW_CYCLES   = 8,
  parameter int INPUT_LIMIT   = 64,
  parameter int RESULT_CYCLES = 4,
  parameter int MAX_TRIES     = 3,
  parameter int WIN_ROUNDS    = 2
) (
  input  logic        CLK,
  input  logic        RST,
  input  logic        start,
  input  logic        question_valid,
  input  logic        question_ok,
  input  logic        clear,
  input  result_t     result,
  output game_state_t state,
  output score_t      score
);

  localparam int LONGEST_A = (SHOW_CYCLES > INPUT_LIMIT) ? SHOW_CYCLES : INPUT_LIMIT;
  localparam int LONGEST   = (LONGEST_A > RESULT_CYCLES) ? LONGEST_A : RESULT_CYCLES;
  localparam int TW        = $clog2(LONGEST + 1);

  typedef logic [TW-1:0] timer_t;

  game_state_t next_state;
  timer_t      timer;     // Cycles left in the current phase
  logic        win_round; // Exact guess this cycle
  logic        lose_try;  // Wrong guess or timeout this cycle
  logic        last_try;

  // Timer load value for the state being entered
  function automatic timer_t phase_len(game_state_t s);
    case (s)
      QUE:               return timer_t'(SHOW_CYCLES - 1);
      INPUT:             return timer_t'(INPUT_LIMIT - 1);
      WRONG, GOOD, OUCH: return timer_t'(RESULT_CYCLES - 1);
      default:           return '0;
    endcase
  endfunction

  assign last_try = (score.tries_left == digit_t'(1));

  always_comb begin
    next_state = state;
    win_round  = 1'b0;
    lose_try   = 1'b0;
    case (state)
      READY: if (start && question_valid && question_ok) next_state = QUE;
      QUE:   if (timer == '0) next_state = INPUT;
      INPUT: begin
        if (result.valid) begin
          if (result.exact) begin
            win_round  = 1'b1;
            next_state = (score.rounds_won == digit_t'(WIN_ROUNDS - 1)) ? WIN : GOOD;
          end else begin
            lose_try   = 1'b1;
            next_state = last_try ? LOSE : WRONG;
          end
        end else if (timer == '0) begin // No decide in time
          lose_try   = 1'b1;
          next_state = last_try ? LOSE : OUCH;
        end
      end
      WRONG, OUCH: if (timer == '0) next_state = INPUT;
      GOOD:        if (timer == '0) next_state = READY;
      WIN, LOSE:   if (clear) next_state = READY; // Game over until cleared
      default:     next_state = READY;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (RST) begin
      state <= READY;
      timer <= '0;
    end else begin
      state <= next_state;
      if (next_state != state)
        timer <= phase_len(next_state); // Reload on every state entry
      else if (timer != '0)
        timer <= timer - 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (RST || ((state == WIN || state == LOSE) && clear)) begin
      score.tries_left <= digit_t'(MAX_TRIES);
      score.rounds_won <= '0;
    end else begin
      if (win_round) score.rounds_won <= score.rounds_won + 1'b1;
      if (lose_try)  score.tries_left <= score.tries_left - 1'b1;
    end
  end

  // A verdict must land while the round is still in INPUT
  a_result_from_input: assert property (@(posedge CLK) disable iff (RST)
    result.valid |-> state == INPUT);

  a_tries_bound: assert property (@(posedge CLK) disable iff (RST)
    score.tries_left <= digit_t'(MAX_TRIES));

endmodule

/* guess_game.f */
common/game_data_pkg.sv
common/game_ctrl_pkg.sv
game_ctrl/game_fsm.sv
logic/digit_entry.sv
logic/guess_check.sv
logic/seg_display.sv
logic/guess_game_top.sv
bench/guess_game_checker.sv
bench/guess_game_tb.sv

/* logic/digit_entry.sv */
`timescale 1ns/1ns

module digit_entry import game_data_pkg::*, game_ctrl_pkg::*; (
  input  logic        CLK,
  input  logic        RST,
  input  game_state_t state,
  input  question_t   question,
  input  logic        start,
  input  logic        question_valid,
  input  step_t       step,
  input  logic        decide,
  output logic        question_ok,
  output question_t   held_q,
  output guess_t      entry,
  output guess_t      guess,
  output logic        guess_strobe,
  output logic        led
);

  logic accept;  // Start taken this cycle
  logic holding; // A question is latched

  function automatic logic digit_ok(digit_t d);
    return (d != '0) && (d <= digit_t'(9));
  endfunction

  // Blank and 9 both move on to 1
  function automatic digit_t next_digit(digit_t d);
    if (d == digit_t'(9))
      return digit_t'(1);
    return d + digit_t'(1);
  endfunction

  assign question_ok = digit_ok(question.d0) && digit_ok(question.d1) &&
                       digit_ok(question.d2);
  assign accept      = (state == READY) && start && question_valid && question_ok;
  assign led         = holding;

  always_ff @(posedge CLK) begin
    if (RST) begin
      held_q  <= '0;
      holding <= 1'b0;
    end else if (accept) begin
      held_q  <= question;
      holding <= 1'b1;
    end else if (state == READY) begin // Round over, let it go
      held_q  <= '0;
      holding <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (RST) begin
      entry <= '0;
    end else if (state == INPUT) begin
      if (step.sel0)
        entry.d0 <= next_digit(entry.d0);
      else if (step.sel1)
        entry.d1 <= next_digit(entry.d1);
      else if (step.sel2)
        entry.d2 <= next_digit(entry.d2);
    end else if (state inside {WRONG, OUCH, GOOD, WIN, LOSE}) begin
      entry <= '0; // Fresh digits for the next attempt
    end
  end

  // Guess snapshot for the checker
  always_ff @(posedge CLK) begin
    if (RST) begin
      guess        <= '0;
      guess_strobe <= 1'b0;
    end else begin
      guess_strobe <= (state == INPUT) && decide;
      if ((state == INPUT) && decide)
        guess <= entry;
    end
  end

  a_entry_range: assert property (@(posedge CLK) disable iff (RST)
    (entry.d0 <= digit_t'(9)) && (entry.d1 <= digit_t'(9)) &&
    (entry.d2 <= digit_t'(9)));

endmodule

/* logic/guess_check.sv */
`timescale 1ns/1ns

module guess_check import game_data_pkg::*, game_ctrl_pkg::*; (
  input  logic      CLK,
  input  logic      RST,
  input  question_t held_q,
  input  guess_t    guess,
  input  logic      guess_strobe,
  output result_t   result
);

  logic  valid_r;
  logic  exact_r;
  hits_t hits_r;
  hits_t hits_now;

  // Position-wise compare, order of digits matters
  function automatic hits_t count_hits(question_t q, guess_t g);
    hits_t n;
    n = '0;
    if (q.d0 == g.d0) n = n + hits_t'(1);
    if (q.d1 == g.d1) n = n + hits_t'(1);
    if (q.d2 == g.d2) n = n + hits_t'(1);
    return n;
  endfunction

  assign hits_now = count_hits(held_q, guess);

  always_ff @(posedge CLK) begin
    if (RST)
      valid_r <= 1'b0;
    else
      valid_r <= guess_strobe; // Single-cycle verdict
  end

  // Verdict stays readable until the next guess
  always_ff @(posedge CLK) begin
    if (guess_strobe) begin
      hits_r  <= hits_now;
      exact_r <= (hits_now == hits_t'(3));
    end
  end

  assign result = '{valid: valid_r, exact: exact_r, hits: hits_r};

endmodule

/* logic/guess_game_top.sv */
`timescale 1ns/1ns

module guess_game_top import game_data_pkg::*, game_ctrl_pkg::*; #(
  parameter int SHOW_CYCLES   = 8,
  parameter int INPUT_LIMIT   = 64,
  parameter int RESULT_CYCLES = 4,
  parameter int MAX_TRIES     = 3,
  parameter int WIN_ROUNDS    = 2
) (
  input  logic            CLK,
  input  logic            RST,
  input  question_t       question,
  input  logic            question_valid,
  input  logic            start,
  input  step_t           step,
  input  logic            decide,
  input  logic            clear,
  output game_state_t     state,
  output result_t         result,
  output score_t          score,
  output logic [5:0][6:0] seg,
  output logic            led
);

  logic      question_ok;
  question_t held_q;
  guess_t    entry;
  guess_t    guess;
  logic      guess_strobe;

  game_fsm #(
    .SHOW_CYCLES   (SHOW_CYCLES),
    .INPUT_LIMIT   (INPUT_LIMIT),
    .RESULT_CYCLES (RESULT_CYCLES),
    .MAX_TRIES     (MAX_TRIES),
    .WIN_ROUNDS    (WIN_ROUNDS)
  ) u_fsm (
    .CLK            (CLK),
    .RST            (RST),
    .start          (start),
    .question_valid (question_valid),
    .question_ok    (question_ok),
    .clear          (clear),
    .result         (result),
    .state          (state),
    .score          (score)
  );

  digit_entry u_entry (
    .CLK            (CLK),
    .RST            (RST),
    .state          (state),
    .question       (question),
    .start          (start),
    .question_valid (question_valid),
    .step           (step),
    .decide         (decide),
    .question_ok    (question_ok),
    .held_q         (held_q),
    .entry          (entry),
    .guess          (guess),
    .guess_strobe   (guess_strobe),
    .led            (led)
  );

  guess_check u_check (
    .CLK          (CLK),
    .RST          (RST),
    .held_q       (held_q),
    .guess        (guess),
    .guess_strobe (guess_strobe),
    .result       (result)
  );

  seg_display u_display (
    .CLK    (CLK),
    .RST    (RST),
    .state  (state),
    .held_q (held_q),
    .entry  (entry),
    .result (result),
    .score  (score),
    .seg    (seg)
  );

endmodule

/* logic/seg_display.sv */
`timescale 1ns/1ns

module seg_display import game_data_pkg::*, game_ctrl_pkg::*; (
  input  logic             CLK,
  input  logic             RST,
  input  game_state_t      state,
  input  question_t        held_q,
  input  guess_t           entry,
  input  result_t          result,
  input  score_t           score,
  output logic [5:0][6:0]  seg
);

  localparam digit_t BLANK = 4'hF; // Any code above 9 lights nothing

  digit_t [5:0] shown;
  hits_t        last_hits;

  // Active-low, bit order gfedcba
  function automatic logic [6:0] to_seg(digit_t d);
    case (d)
      4'd0:    return 7'b1000000;
      4'd1:    return 7'b1111001;
      4'd2:    return 7'b0100100;
      4'd3:    return 7'b0110000;
      4'd4:    return 7'b0011001;
      4'd5:    return 7'b0010010;
      4'd6:    return 7'b0000010;
      4'd7:    return 7'b1111000;
      4'd8:    return 7'b0000000;
      4'd9:    return 7'b0010000;
      default: return 7'b1111111;
    endcase
  endfunction

  always_ff @(posedge CLK) begin
    if (RST)
      last_hits <= '0;
    else if (result.valid)
      last_hits <= result.hits;
  end

  always_ff @(posedge CLK) begin
    if (RST) begin
      shown <= {6{BLANK}};
    end else begin
      shown    <= {score.rounds_won, score.tries_left, BLANK, BLANK, BLANK, BLANK};
      case (state)
        QUE:   shown[2:0] <= {held_q.d2, held_q.d1, held_q.d0};
        INPUT: shown[2:0] <= {entry.d2, entry.d1, entry.d0};
        WRONG: shown[3]   <= digit_t'(last_hits); // Hit count of the miss
        default: ;
      endcase
    end
  end

  always_comb begin
    for (int i = 0; i < 6; i++)
      seg[i] = to_seg(shown[i]);
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Verilator build and run, pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module guess_game_tb \
    -f guess_game.f -o guess_game_sim \
  && ./obj_dir/guess_game_sim > sim.log 2>&1 \
  || { echo "Build or run failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qx "TEST OK" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
